// ==== vlog.f ====
verilog/tetris_pkg.sv
verilog/prng.sv
verilog/control.sv
verilog/piece_queue.sv
verilog/game_state.sv
verilog/status_text.sv
verilog/tetris_status_top.sv
testbench/clock_gen.sv
testbench/tetris_status_checker.sv
testbench/tb_tetris_status.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tetris_status -f vlog.f

out=$(./obj_dir/Vtb_tetris_status +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^All checks passed$"; then
  exit 0
fi
exit 1

// ==== testbench/tb_tetris_status.sv ====
`timescale 1ns/1ns

module tb_tetris_status import tetris_pkg::*; ();

  localparam logic [127:0] HEX_DIGITS = "0123456789ABCDEF";

  typedef struct {
    logic [3:0]      btn;
    logic [3:0]      sw;
    logic [ROWS-1:0] mask;
    ctrl_t           cmd; // expected command.
  } entry_t;

  logic            clk_50MHz;
  logic            reset_n;
  logic [3:0]      usr_btn;
  logic [3:0]      usr_sw;
  logic [ROWS-1:0] bar_mask;
  queue_t          queue;
  status_t         status;
  logic [127:0]    row_a;
  logic [127:0]    row_b;

  entry_t      table_q[$];
  logic [31:0] model_rng;
  queue_t      model_q;
  status_t     model_s;
  int          model_score;
  logic        hold_used;
  int          cycles = 0;
  int          cycle_limit;
  kind_t       piece_map[8] = '{T, I, J, L, O, S, T, Z}; // zero draws a T.

  clock_gen clock_gen_i (.clk_50MHz (clk_50MHz), .reset_n (reset_n));

  tetris_status_top dut_i (.*);

  bind tetris_status_top tetris_status_checker chk_i (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] r);
    return {1'b0, r[31:1]} ^ (r[0] ? PRNG_TAPS : 32'h0);
  endfunction

  function automatic logic [7:0] hex_char(input logic [3:0] n);
    return HEX_DIGITS[127 - 8 * int'(n) -: 8];
  endfunction

  function automatic logic [127:0] text_row(input logic [7:0] code, input logic [15:0] score,
                                            input bit show_score);
    logic [127:0] row;
    row = {16{" "}};
    row[127 -: 16] = {hex_char(code[7:4]), hex_char(code[3:0])};
    if (show_score) begin
      for (int p = 0; p < 4; p++) begin
        row[63 - 8 * p -: 8] = hex_char(score[15 - 4 * p -: 4]); // chars 8 to 11.
      end
    end
    return row;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_queue(input queue_t got, input queue_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: queue %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: status %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_row(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s \"%s\", expected \"%s\"", $time, name, got, exp));
    end
  endtask

  task automatic check_all();
    if (dut_i.chk_i.fail_count != 0) begin
      stop_run("an assertion in the bound checker failed");
    end
    check_queue(queue, model_q);
    check_status(status, model_s);
    check_row("row_a", row_a, text_row(model_s.state, 16'h0, 1'b0));
    check_row("row_b", row_b, text_row(model_s.last_cmd, model_s.score, 1'b1));
  endtask

  task automatic add_entry(input logic [3:0] btn, input logic [3:0] sw,
                           input logic [31:0] mask, input ctrl_t cmd);
    table_q.push_back('{btn: btn, sw: sw, mask: mask[ROWS-1:0], cmd: cmd});
  endtask

  // steps the reference models by one entry.
  // r is the rng word seen on the command edge.
  task automatic run_model(input entry_t e, input logic [31:0] r);
    int    hits;
    kind_t parked;
    hits = 0;
    parked = model_q.kind;
    for (int b = 0; b < ROWS; b++) begin
      hits += int'(e.mask[b]);
    end
    model_s.state = !e.sw[0] ? IDLE : (e.sw[1] ? PAUSE : PLAY);
    if (e.cmd != NONE) model_s.last_cmd = e.cmd;
    if (model_s.state != PLAY) return;
    if (e.cmd == DROP || (e.cmd == HOLD && !hold_used && model_q.hold == EMPTY)) begin
      model_q = {model_q.next0, model_q.hold, model_q.next1, model_q.next2, model_q.next3,
                 piece_map[r[2:0]]};
    end
    if (e.cmd == HOLD && !hold_used) begin
      if (model_q.hold != EMPTY) model_q.kind = model_q.hold;
      model_q.hold = parked;
      hold_used = 1'b1;
    end
    if (e.cmd == DROP) begin
      hold_used = 1'b0;
      model_score = (model_score + hits > 9999) ? 9999 : model_score + hits;
      model_s.score = {4'(model_score / 1000), 4'(model_score / 100 % 10),
                       4'(model_score / 10 % 10), 4'(model_score % 10)};
    end
  endtask

  always @(posedge clk_50MHz) begin
    model_rng <= !reset_n ? PRNG_SEED : lfsr_next(model_rng);
  end

  always @(posedge clk_50MHz) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      stop_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    logic [31:0] r;
    kind_t       p[5];
    entry_t      e;
    usr_btn = 4'b0000;
    usr_sw = 4'b0000;
    bar_mask = '0;
    void'($urandom(32'h197ebc3f));
    add_entry(4'b0001, 4'b0000, 0, LEFT); // idle presses.
    add_entry(4'b0100, 4'b0000, 0, ROTATE);
    add_entry(4'b1000, 4'b0000, 32'h3ff, DROP);
    add_entry(4'b0000, 4'b0001, 0, NONE); // start.
    add_entry(4'b1000, 4'b0001, 32'h007, DROP);
    add_entry(4'b1000, 4'b0001, $urandom(), DROP);
    add_entry(4'b1000, 4'b0001, $urandom(), DROP);
    add_entry(4'b0100, 4'b1001, 0, HOLD); // empty slot.
    add_entry(4'b0100, 4'b1001, 0, HOLD);
    add_entry(4'b1000, 4'b1001, $urandom(), DROP);
    add_entry(4'b0100, 4'b1001, 0, HOLD); // swap.
    add_entry(4'b0100, 4'b1001, 0, HOLD);
    add_entry(4'b0000, 4'b0011, 0, NONE); // pause.
    add_entry(4'b1000, 4'b0011, 32'h3ff, DROP);
    add_entry(4'b0110, 4'b0011, 0, RIGHT);
    add_entry(4'b1100, 4'b0011, 0, ROTATE);
    add_entry(4'b1100, 4'b1011, 0, HOLD);
    add_entry(4'b1111, 4'b1011, 0, LEFT);
    add_entry(4'b0000, 4'b0001, 0, NONE); // resume.
    add_entry(4'b0100, 4'b0001, 0, ROTATE);
    add_entry(4'b0010, 4'b0001, 0, RIGHT);
    repeat (1002) add_entry(4'b1000, 4'b0001, 32'h3ff, DROP);
    add_entry(4'b0000, 4'b0000, 0, NONE); // back to idle.
    add_entry(4'b1000, 4'b0000, 32'h3ff, DROP);
    cycle_limit = table_q.size() * 12 + 50;

    r = PRNG_SEED;
    for (int i = 0; i < 5; i++) begin
      p[i] = piece_map[r[2:0]];
      r = lfsr_next(r);
    end
    model_q = {p[0], EMPTY, p[1], p[2], p[3], p[4]}; // first draw ends up current.
    model_s = '{state: IDLE, last_cmd: NONE, score: 16'h0000};
    model_score = 0;
    hold_used = 1'b0;

    wait (reset_n === 1'b1);
    repeat (8) @(posedge clk_50MHz);
    #1 check_all();
    #1;
    foreach (table_q[i]) begin
      e = table_q[i];
      usr_btn = e.btn;
      usr_sw = e.sw;
      bar_mask = e.mask;
      repeat (2) @(posedge clk_50MHz);
      #2 usr_btn = 4'b0000;
      @(posedge clk_50MHz);
      #1 r = model_rng; // cmd is on the bus now.
      run_model(e, r);
      repeat (3) @(posedge clk_50MHz);
      #1 check_all();
      repeat (4) @(posedge clk_50MHz);
      #2;
    end

    if (dut_i.chk_i.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_run("an assertion in the bound checker failed");
    end
  end

endmodule

// ==== testbench/tetris_status_checker.sv ====
`timescale 1ns/1ns

module tetris_status_checker import tetris_pkg::*;
(
  input logic         clk_50MHz,
  input logic         reset_n,
  input ctrl_t        cmd,
  input queue_t       queue,
  input status_t      status,
  input logic [127:0] row_a,
  input logic [127:0] row_b
);

  int         fail_count = 0;
  logic [2:0] since_reset; // stops at five.

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      since_reset <= '0;
    end else if (since_reset != 3'd5) begin
      since_reset <= since_reset + 3'd1;
    end
  end

  cmd_single_pulse: assert property (@(posedge clk_50MHz) disable iff (!reset_n)
    cmd != NONE |=> cmd == NONE)
  else begin
    $error("cmd active on two cycles in a row");
    fail_count++;
  end

  kind_filled: assert property (@(posedge clk_50MHz) disable iff (!reset_n)
    since_reset == 3'd5 |-> queue.kind != EMPTY)
  else begin
    $error("current piece is EMPTY after the queue filled");
    fail_count++;
  end

  score_digits: assert property (@(posedge clk_50MHz) disable iff (!reset_n)
    status.score[15:12] <= 4'd9 && status.score[11:8] <= 4'd9 &&
    status.score[7:4] <= 4'd9 && status.score[3:0] <= 4'd9)
  else begin
    $error("score digit above 9");
    fail_count++;
  end

  rows_follow: assert property (@(posedge clk_50MHz) disable iff (!reset_n)
    !$stable(status) |=> !$stable({row_a, row_b}))
  else begin
    $error("status changed but the rows did not");
    fail_count++;
  end

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
  output logic clk_50MHz,
  output logic reset_n
);

  initial begin
    clk_50MHz = 1'b0;
    forever #10 clk_50MHz = ~clk_50MHz; // 20 ns period.
  end

  initial begin
    reset_n = 1'b0;
    repeat (10) @(posedge clk_50MHz);
    #2 reset_n = 1'b1;
  end

endmodule

// ==== verilog/tetris_status_top.sv ====
`timescale 1ns/1ns

module tetris_status_top import tetris_pkg::*;
(
  input  logic            clk_50MHz,
  input  logic            reset_n,
  input  logic [3:0]      usr_btn,
  input  logic [3:0]      usr_sw,
  input  logic [ROWS-1:0] bar_mask,
  output queue_t          queue,
  output status_t         status,
  output logic [127:0]    row_a,
  output logic [127:0]    row_b
);

  logic [31:0] rng;
  ctrl_t       cmd;
  logic        start;
  logic        pause;
  logic        playing;

  prng prng_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .rng       (rng)
  );

  control control_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .usr_btn   (usr_btn),
    .usr_sw    (usr_sw),
    .cmd       (cmd),
    .start     (start),
    .pause     (pause)
  );

  piece_queue piece_queue_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .rng       (rng),
    .cmd       (cmd),
    .playing   (playing),
    .queue     (queue)
  );

  game_state game_state_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .start     (start),
    .pause     (pause),
    .bar_mask  (bar_mask),
    .playing   (playing),
    .status    (status)
  );

  status_text status_text_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .status    (status),
    .row_a     (row_a),
    .row_b     (row_b)
  );

endmodule

// ==== verilog/status_text.sv ====
`timescale 1ns/1ns

module status_text import tetris_pkg::*;
(
  input  logic         clk_50MHz,
  input  logic         reset_n,
  input  status_t      status,
  output logic [127:0] row_a,
  output logic [127:0] row_b
);

  logic [7:0]  state_code;
  logic [7:0]  cmd_code;
  logic [15:0] score;

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib}; // "0".."9".
    end
    return 8'h37 + {4'h0, nib}; // "A".."F".
  endfunction

  assign state_code = status.state;
  assign cmd_code   = status.last_cmd;
  assign score      = status.score;

  // position 0 is the top byte.
  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      row_a <= ROW_BLANK;
      row_b <= ROW_BLANK;
    end else begin
      row_a <= {hex_char(state_code[7:4]), hex_char(state_code[3:0]),
                {14{TEXT_FILL}}};
      row_b <= {hex_char(cmd_code[7:4]), hex_char(cmd_code[3:0]),
                {6{TEXT_FILL}},
                hex_char(score[15:12]), hex_char(score[11:8]),
                hex_char(score[7:4]), hex_char(score[3:0]),
                {4{TEXT_FILL}}}; // score sits in 8 to 11.
    end
  end

endmodule

// ==== verilog/game_state.sv ====
`timescale 1ns/1ns

module game_state import tetris_pkg::*;
(
  input  logic            clk_50MHz,
  input  logic            reset_n,
  input  ctrl_t           cmd,
  input  logic            start,
  input  logic            pause,
  input  logic [ROWS-1:0] bar_mask,
  output logic            playing,
  output status_t         status
);

  logic [4:0] hits;
  state_t     next_state;

  // bcd add with saturation at 9999.
  function automatic logic [15:0] bcd_add(input logic [15:0] s, input logic [4:0] n);
    logic [4:0]  carry;
    logic [4:0]  d;
    logic [15:0] r;
    carry = n;
    for (int k = 0; k < 4; k++) begin
      d = {1'b0, s[4*k +: 4]} + carry;
      if (d > 5'd9) begin
        r[4*k +: 4] = 4'(d - 5'd10);
        carry = 5'd1;
      end else begin
        r[4*k +: 4] = d[3:0];
        carry = 5'd0;
      end
    end
    return (carry != 5'd0) ? 16'h9999 : r;
  endfunction

  assign hits = 5'($countones(bar_mask));
  assign playing = (status.state == PLAY);

  always_comb begin
    next_state = status.state;
    if (!start) begin
      next_state = IDLE; // score survives.
    end else begin
      case (status.state)
        IDLE:    next_state = PLAY;
        PLAY:    if (pause) next_state = PAUSE;
        PAUSE:   if (!pause) next_state = PLAY;
        default: next_state = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      status <= '{state: IDLE, last_cmd: NONE, score: 16'h0000};
    end else begin
      status.state <= next_state;
      if (cmd != NONE) status.last_cmd <= cmd;
      if (cmd == DROP && playing) status.score <= bcd_add(status.score, hits);
    end
  end

endmodule

// ==== verilog/piece_queue.sv ====
`timescale 1ns/1ns

module piece_queue import tetris_pkg::*;
(
  input  logic        clk_50MHz,
  input  logic        reset_n,
  input  logic [31:0] rng,
  input  ctrl_t       cmd,
  input  logic        playing,
  output queue_t      queue
);

  logic [2:0] fill_cnt;
  logic       filled;
  logic       hold_used; // one hold per drop.
  kind_t      new_piece;
  queue_t     q_adv;
  queue_t     q_hold;
  queue_t     q_swap;

  assign filled = (fill_cnt == 3'(NEXT_DEPTH + 1));

  always_comb begin
    // zero maps to T so no new piece is ever EMPTY.
    new_piece = (rng[2:0] == 3'd0) ? T : kind_t'({1'b0, rng[2:0]});

    q_adv       = queue;
    q_adv.kind  = queue.next0;
    q_adv.next0 = queue.next1;
    q_adv.next1 = queue.next2;
    q_adv.next2 = queue.next3;
    q_adv.next3 = new_piece;

    q_hold      = q_adv;
    q_hold.hold = queue.kind; // first hold parks the piece.

    q_swap      = queue;
    q_swap.kind = queue.hold;
    q_swap.hold = queue.kind;
  end

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      queue     <= '{default: EMPTY};
      fill_cnt  <= '0;
      hold_used <= 1'b0;
    end else if (!filled) begin
      queue    <= q_adv; // shift in pieces after reset.
      fill_cnt <= fill_cnt + 3'd1;
    end else if (playing) begin
      case (cmd)
        DROP: begin
          queue     <= q_adv;
          hold_used <= 1'b0;
        end
        HOLD: begin
          if (!hold_used) begin
            queue     <= (queue.hold == EMPTY) ? q_hold : q_swap;
            hold_used <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== verilog/control.sv ====
`timescale 1ns/1ns

module control import tetris_pkg::*;
(
  input  logic       clk_50MHz,
  input  logic       reset_n,
  input  logic [3:0] usr_btn,
  input  logic [3:0] usr_sw,
  output ctrl_t      cmd,
  output logic       start,
  output logic       pause
);

  logic [3:0] btn_s1;
  logic [3:0] btn_s2;
  logic [3:0] btn_d;
  logic [2:0] sw_s1; // {hold mode, pause, start}.
  logic [2:0] sw_s2;
  logic [3:0] rise;
  ctrl_t      next_cmd;

  assign rise = btn_s2 & ~btn_d;

  // lowest button index wins.
  always_comb begin
    if (rise[0]) begin
      next_cmd = LEFT;
    end else if (rise[1]) begin
      next_cmd = RIGHT;
    end else if (rise[2]) begin
      next_cmd = sw_s2[2] ? HOLD : ROTATE;
    end else if (rise[3]) begin
      next_cmd = DROP;
    end else begin
      next_cmd = NONE;
    end
  end

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      btn_s1 <= '0;
      btn_s2 <= '0;
      btn_d  <= '0;
      sw_s1  <= '0;
      sw_s2  <= '0;
      cmd    <= NONE;
    end else begin
      btn_s1 <= usr_btn;
      btn_s2 <= btn_s1;
      btn_d  <= btn_s2;
      sw_s1  <= {usr_sw[3], usr_sw[1:0]}; // sw2 has no function.
      sw_s2  <= sw_s1;
      cmd    <= next_cmd; // one cycle pulse.
    end
  end

  assign start = sw_s2[0];
  assign pause = sw_s2[1];

endmodule

// ==== verilog/prng.sv ====
`timescale 1ns/1ns

module prng import tetris_pkg::*;
(
  input  logic        clk_50MHz,
  input  logic        reset_n,
  output logic [31:0] rng
);

  // galois form shifting right every cycle.
  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      rng <= PRNG_SEED;
    end else if (rng[0]) begin
      rng <= (rng >> 1) ^ PRNG_TAPS;
    end else begin
      rng <= rng >> 1;
    end
  end

endmodule

// ==== verilog/tetris_pkg.sv ====
package tetris_pkg;

  localparam int NEXT_DEPTH = 4; // preview depth.
  localparam int ROWS = 10;

  localparam logic [31:0] PRNG_SEED = 32'hACE1_2468;
  localparam logic [31:0] PRNG_TAPS = 32'h8020_0003; // galois feedback mask.

  localparam logic [7:0] TEXT_FILL = 8'h20; // ascii space.
  localparam logic [127:0] ROW_BLANK = {16{TEXT_FILL}};

  // 8 bits wide so each prints as two hex characters.
  typedef enum logic [7:0] {
    NONE,
    LEFT,
    RIGHT,
    ROTATE,
    DROP,
    HOLD
  } ctrl_t;

  typedef enum logic [7:0] {
    IDLE,
    PLAY,
    PAUSE
  } state_t;

  typedef enum logic [3:0] {
    EMPTY, // unused hold slot.
    I, J, L, O, S, T, Z
  } kind_t;

  typedef struct packed {
    kind_t kind;
    kind_t hold;
    kind_t next0;
    kind_t next1;
    kind_t next2;
    kind_t next3;
  } queue_t;

  typedef struct packed {
    state_t state;
    ctrl_t last_cmd;
    logic [15:0] score; // four bcd digits.
  } status_t;

endpackage
